/* Makefile */
TOP = tb_maze

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* files.f */
maze_pkg.sv
maze_move_if.sv
maze_button_press.sv
maze_move_check.sv
maze_mazer_locator.sv
maze_game_ctrl.sv
maze_top.sv
tb_clock_gen.sv
tb_maze.sv

/* maze_button_press.sv */
// Press detector that turns a held one-hot button code into one single-cycle press event.
`default_nettype none
`timescale 1ns/1ps

module maze_button_press (
    input  logic              clk,
    input  logic              nrst,
    input  maze_pkg::button_t button,
    output logic              press_valid,
    output maze_pkg::button_t press_btn
);
    import maze_pkg::*;

    button_t btn_q;                        // Sampled button code.
    button_t btn_prev;                     // Code one cycle earlier.
    logic    new_press;

    // A press is a clean one-hot code right after an idle cycle.
    assign new_press = (btn_prev == NO_PRESS) && $onehot(btn_q);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            btn_q       <= NO_PRESS;
            btn_prev    <= NO_PRESS;
            press_valid <= 1'b0;
        end else begin
            btn_q       <= button;
            btn_prev    <= btn_q;
            press_valid <= new_press;
        end
    end

    // Code travels with the pulse.
    always_ff @(posedge clk) begin
        if (new_press) begin
            press_btn <= btn_q;
        end
    end

    // A held button never repeats the event since each press needs an idle sample first.
    a_single_press : assert property (
        @(posedge clk) disable iff (!nrst)
        press_valid |-> ($past(button, 3) == NO_PRESS) && ($past(button, 2) == press_btn)
    );

endmodule

`default_nettype wire

/* maze_cases.txt */
// Hex columns: button start_x start_y hold_cycles exp_pos_x exp_pos_y exp_game_state
// Game one walks to the goal, game two burns the move budget.
00 0 0 1 0 0 0
02 0 0 1 0 0 0
03 0 0 2 0 0 0
01 0 0 2 0 0 1
04 0 0 1 0 0 1
10 0 0 4 1 0 1
10 0 0 1 1 0 1
02 0 0 1 1 1 1
10 0 0 1 2 1 1
08 0 0 1 2 1 1
10 0 0 1 3 1 1
10 0 0 1 4 1 1
02 0 0 1 4 2 1
10 0 0 1 5 2 1
02 0 0 1 5 2 1
3f 0 0 1 5 2 1
04 0 0 1 4 2 1
02 0 0 1 4 3 1
02 0 0 1 4 4 1
02 0 0 1 4 5 1
10 0 0 1 7 7 3
20 0 0 1 7 7 0
01 3 3 2 3 3 1
02 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
02 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 3 3 1
10 3 3 1 4 3 1
04 3 3 1 7 7 2
20 3 3 1 7 7 0

/* maze_game_ctrl.sv */
// Game controller FSM with the move budget counter, goal detection and the start-load pulse.
`default_nettype none
`timescale 1ns/1ps

module maze_game_ctrl #(
    parameter int MAX_MOVES = 20
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  press_valid,
    input  maze_pkg::button_t     press_btn,
    maze_move_if.monitor          move,
    output maze_pkg::game_state_t game_state,
    output logic                  load_start
);
    import maze_pkg::*;

    localparam int CNT_W = (MAX_MOVES < 1) ? 1 : $clog2(MAX_MOVES + 1);

    logic [CNT_W-1:0] move_cnt;            // Accepted moves this game.
    logic             at_goal;
    logic             out_of_moves;

    assign at_goal      = (move.pos_x == GOAL_X) && (move.pos_y == GOAL_Y);
    assign out_of_moves = (move_cnt == CNT_W'(MAX_MOVES));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state <= MENU;
            load_start <= 1'b0;
            move_cnt   <= '0;
        end else begin
            load_start <= 1'b0;
            case (game_state)
                MENU: begin
                    if (press_valid && press_btn == SELECT) begin
                        game_state <= PLAY;
                        load_start <= 1'b1;
                        move_cnt   <= '0;
                    end
                end
                PLAY: begin
                    if (at_goal) begin
                        game_state <= WON;   // Goal beats an empty budget.
                    end else if (out_of_moves) begin
                        game_state <= LOST;
                    end
                    // Saturates at the budget.
                    if (move.valid && !out_of_moves) begin
                        move_cnt <= move_cnt + 1'b1;
                    end
                end
                WON, LOST: begin
                    if (press_valid && press_btn == BACK) begin
                        game_state <= MENU;
                    end
                end
                default: game_state <= MENU;
            endcase
        end
    end

    // Start load only comes from the menu, with no move in flight on the bus.
    a_load_from_menu : assert property (
        @(posedge clk) disable iff (!nrst)
        load_start |-> ($past(game_state) == MENU) && !move.valid
    );

endmodule

`default_nettype wire

/* maze_mazer_locator.sv */
// Mazer locator that holds the position, applies moves, loads the start cell and parks at game end.
`default_nettype none
`timescale 1ns/1ps

module maze_mazer_locator (
    input  logic                  clk,
    input  logic                  nrst,
    input  maze_pkg::game_state_t game_state,
    input  logic                  load_start,
    input  maze_pkg::coord_t      start_pos_x,
    input  maze_pkg::coord_t      start_pos_y,
    maze_move_if.locator          move
);
    import maze_pkg::*;

    coord_t next_x;
    coord_t next_y;
    logic   load_d;                        // Start load, one cycle late.

    always_ff @(posedge clk) begin
        if (!nrst) begin
            move.pos_x <= 3'd0;
            move.pos_y <= 3'd0;
            load_d     <= 1'b0;
        end else begin
            move.pos_x <= next_x;
            move.pos_y <= next_y;
            load_d     <= load_start;
        end
    end

    always_comb begin
        next_x = move.pos_x;
        next_y = move.pos_y;
        if (load_d) begin
            next_x = start_pos_x;
            next_y = start_pos_y;
        end else if (game_state == WON || game_state == LOST) begin
            // Game over, hide the mazer.
            next_x = OFF_GRID;
            next_y = OFF_GRID;
        end else if (move.valid) begin
            case (move.dir)
                UP:      next_y = move.pos_y + 3'd1;
                DOWN:    next_y = move.pos_y - 3'd1;
                LEFT:    next_x = move.pos_x + 3'd1;
                RIGHT:   next_x = move.pos_x - 3'd1;
                default: ;                 // Hold.
            endcase
        end
    end

endmodule

`default_nettype wire

/* maze_move_check.sv */
// Move check stage that tests direction presses against the walls and the grid border.
`default_nettype none
`timescale 1ns/1ps

module maze_move_check (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  press_valid,
    input  maze_pkg::button_t     press_btn,
    input  maze_pkg::game_state_t game_state,
    maze_move_if.check            move
);
    import maze_pkg::*;

    localparam coord_t      EDGE_HI  = coord_t'(GRID_SIZE - 1);
    localparam logic [5:0]  ROW_STEP = 6'(GRID_SIZE);

    logic [5:0] here;                      // Wall map index of the current cell.
    logic       on_grid;
    logic       allowed;
    logic       accept;

    // Flat cell index into the wall maps.
    function automatic logic [5:0] cell_idx(input coord_t x, input coord_t y);
        return 6'(int'(y) * GRID_SIZE + int'(x));
    endfunction

    assign here    = cell_idx(move.pos_x, move.pos_y);
    assign on_grid = (move.pos_x <= EDGE_HI) && (move.pos_y <= EDGE_HI);

    always_comb begin
        allowed = 1'b0;
        if (on_grid) begin
            case (press_btn)
                UP:      allowed = (move.pos_y != EDGE_HI) && !WALL_NORTH[here];
                DOWN:    allowed = (move.pos_y != 3'd0) && !WALL_NORTH[here - ROW_STEP];
                LEFT:    allowed = (move.pos_x != EDGE_HI) && !WALL_EAST[here];
                RIGHT:   allowed = (move.pos_x != 3'd0) && !WALL_EAST[here - 6'd1];
                default: allowed = 1'b0;   // SELECT, BACK and junk.
            endcase
        end
    end

    assign accept = press_valid && (game_state == PLAY) && allowed;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            move.valid <= 1'b0;
        end else begin
            move.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            move.dir <= press_btn;
        end
    end

    // The locator must land on a real cell after a move issued during play.
    a_move_on_grid : assert property (
        @(posedge clk) disable iff (!nrst)
        move.valid && (game_state == PLAY) |=>
            (move.pos_x <= EDGE_HI) && (move.pos_y <= EDGE_HI)
    );

endmodule

`default_nettype wire

/* maze_move_if.sv */
// Move bus between the check stage, the locator and the game controller.
`default_nettype none
`timescale 1ns/1ps

interface maze_move_if;
    import maze_pkg::*;

    logic        valid;                    // One-cycle pulse per allowed move.
    button_t     dir;
    coord_t      pos_x;                    // Registered mazer position.
    coord_t      pos_y;

    modport check (
        output valid, dir,
        input  pos_x, pos_y
    );

    modport locator (
        input  valid, dir,
        output pos_x, pos_y
    );

    modport monitor (
        input  valid, dir, pos_x, pos_y
    );

endinterface

`default_nettype wire

/* maze_pkg.sv */
// Maze game package with state and button codes, grid constants and the fixed wall maps.
`default_nettype none

package maze_pkg;

    // Game states, encoded as the original locator expects them.
    typedef enum logic [2:0] {
        MENU = 3'b000,
        PLAY = 3'b001,
        LOST = 3'b010,
        WON  = 3'b011
    } game_state_t;

    // One-hot button codes.
    typedef enum logic [5:0] {
        NO_PRESS = 6'b000000,
        SELECT   = 6'b000001,
        UP       = 6'b000010,
        RIGHT    = 6'b000100,
        DOWN     = 6'b001000,
        LEFT     = 6'b010000,
        BACK     = 6'b100000
    } button_t;

    typedef logic [2:0] coord_t;           // 0..5 on grid, 7 off grid.

    localparam int     GRID_SIZE = 6;
    localparam coord_t OFF_GRID  = 3'd7;
    localparam coord_t GOAL_X    = 3'd5;
    localparam coord_t GOAL_Y    = 3'd5;

    // Bit y*6+x blocks the step between (x,y) and (x+1,y).
    // Walls east of (1,0) (4,1) (2,2) (0,3) (3,4).
    localparam logic [35:0] WALL_EAST  = 36'h0_0804_4402;

    // Bit y*6+x blocks the step between (x,y) and (x,y+1).
    // Walls north of (2,0) (0,1) (5,2) (3,3) (1,4).
    localparam logic [35:0] WALL_NORTH = 36'h0_0222_0044;

endpackage

`default_nettype wire

/* maze_top.sv */
// Maze game core top level joining press detection, move check, locator and game controller.
`default_nettype none
`timescale 1ns/1ps

module maze_top #(
    parameter int MAX_MOVES = 20
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic [5:0] button,
    input  logic [2:0] start_pos_x,
    input  logic [2:0] start_pos_y,
    output logic [2:0] pos_x,
    output logic [2:0] pos_y,
    output logic [2:0] game_state
);
    import maze_pkg::*;

    logic        press_valid;
    button_t     press_btn;
    game_state_t state;
    logic        load_start;

    maze_move_if move_bus ();

    maze_button_press i_press (
        .clk         (clk),
        .nrst        (nrst),
        .button      (button_t'(button)),
        .press_valid (press_valid),
        .press_btn   (press_btn)
    );

    maze_move_check i_check (
        .clk         (clk),
        .nrst        (nrst),
        .press_valid (press_valid),
        .press_btn   (press_btn),
        .game_state  (state),
        .move        (move_bus.check)
    );

    maze_mazer_locator i_locator (
        .clk         (clk),
        .nrst        (nrst),
        .game_state  (state),
        .load_start  (load_start),
        .start_pos_x (start_pos_x),
        .start_pos_y (start_pos_y),
        .move        (move_bus.locator)
    );

    maze_game_ctrl #(
        .MAX_MOVES   (MAX_MOVES)
    ) i_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .press_valid (press_valid),
        .press_btn   (press_btn),
        .move        (move_bus.monitor),
        .game_state  (state),
        .load_start  (load_start)
    );

    assign pos_x      = move_bus.pos_x;
    assign pos_y      = move_bus.pos_y;
    assign game_state = state;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock source with a free running clock of configurable period.
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0) clk = ~clk;     // Half period per phase.
    end

endmodule

`default_nettype wire

/* tb_maze.sv */
// Testbench for the maze game core that replays button presses from the case file.
`default_nettype none
`timescale 1ns/1ps

module tb_maze;

    localparam int MAX_CASES = 64;
    localparam int FIELDS    = 7;          // Columns per case line.
    localparam int SETTLE    = 5;          // Cycles from release to check.

    logic       clk;
    logic       nrst;
    logic [5:0] button;
    logic [2:0] start_pos_x;
    logic [2:0] start_pos_y;
    logic [2:0] pos_x;
    logic [2:0] pos_y;
    logic [2:0] game_state;

    logic [7:0] case_mem [0:MAX_CASES*FIELDS-1];
    int         num_cases;
    int         errors;
    int         cycles;
    int         cycle_limit;

    tb_clock_gen #(
        .PERIOD_NS   (8.0)
    ) i_clk (
        .clk         (clk)
    );

    maze_top #(
        .MAX_MOVES   (20)
    ) i_dut (
        .clk         (clk),
        .nrst        (nrst),
        .button      (button),
        .start_pos_x (start_pos_x),
        .start_pos_y (start_pos_y),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .game_state  (game_state)
    );

    // Compare one DUT output with its expected value.
    task automatic compare(input string name, input int idx, input logic [7:0] got,
                           input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t case %0d %s: got %0h, expected %0h",
                     $time, idx, name, got, exp);
        end
    endtask

    // Press, hold, release, let the pipeline settle, then check.
    task automatic play_case(input int idx);
        logic [7:0] hold;
        int         base;
        base = idx * FIELDS;
        hold = case_mem[base+3];
        @(negedge clk);
        button      = case_mem[base][5:0];
        start_pos_x = case_mem[base+1][2:0];
        start_pos_y = case_mem[base+2][2:0];
        repeat (int'(hold)) @(negedge clk);
        button = 6'd0;
        repeat (SETTLE) @(negedge clk);
        compare("pos_x", idx, {5'd0, pos_x}, case_mem[base+4]);
        compare("pos_y", idx, {5'd0, pos_y}, case_mem[base+5]);
        compare("game_state", idx, {5'd0, game_state}, case_mem[base+6]);
    endtask

    // Run length guard.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        errors      = 0;
        cycles      = 0;
        nrst        = 1'b0;
        button      = 6'd0;
        start_pos_x = 3'd0;
        start_pos_y = 3'd0;
        for (int i = 0; i < MAX_CASES * FIELDS; i++) begin
            case_mem[i] = 8'hff;           // Marks unused rows.
        end
        $readmemh("maze_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != 8'hff) begin
            num_cases++;
        end
        cycle_limit = 12 * num_cases + 50;
        if (num_cases == 0) begin
            errors++;
            $display("No cases could be read from maze_cases.txt");
        end
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        for (int idx = 0; idx < num_cases; idx++) begin
            play_case(idx);
        end
        $display("Checks done: %0d cases, %0d errors", num_cases, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
